// File: vlog.f
rtl/mipsPkg.sv
rtl/instrMemory.sv
rtl/registerFile.sv
rtl/controlDecoder.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/dataMemory.sv
rtl/mipsPipeline.sv
verif/mipsPipeline_properties.sv
verif/mipsPipeline_tb.sv

// File: verif/mipsPipeline_tb.sv
`default_nettype none

module mipsPipeline_tb;

	localparam int imemWords = 64;
	localparam int dmemWords = 64;
	localparam int addrBits = $clog2(imemWords);
	localparam int clkPeriod = 10;
	localparam int resetCycles = 5;
	// cycles after the halt reaches memory
	localparam int drainCycles = 8;
	// reset, full program load and register readout
	localparam int setupCycles = resetCycles + imemWords + 40;
	// execution budget of each test
	localparam int arithBudget = 100;
	localparam int fwdBudget = 100;
	localparam int memBudget = 100;
	localparam int branchBudget = 100;
	localparam int pauseBudget = 300;
	localparam int totalCycles = 5 * setupCycles + arithBudget + fwdBudget
		+ memBudget + branchBudget + pauseBudget;
	localparam int watchdogTime = totalCycles * clkPeriod * 2;

	logic clk = 1'b1;
	logic reset;
	logic run;
	logic imemWe;
	logic [addrBits-1:0] imemAddr;
	mipsPkg::word_t imemData;
	mipsPkg::regAddr_t dbgAddr;
	mipsPkg::word_t dbgData;
	mipsPkg::word_t pc;

	// program image for the current test
	mipsPkg::word_t code [$];
	int testErrors = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;

	mipsPipeline #(.imemWords(imemWords), .dmemWords(dmemWords)) UUT (
		.clk(clk), .reset(reset), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
		.imemData(imemData), .dbgAddr(dbgAddr), .dbgData(dbgData), .pc(pc)
	);

	// starts high so the first falling edge comes half a period in
	always #(clkPeriod / 2) clk = ~clk;

	//////////////////////////////
	// instruction encoding
	//////////////////////////////

	function automatic mipsPkg::word_t encodeR(input mipsPkg::funct_t f,
		input mipsPkg::regAddr_t rd, input mipsPkg::regAddr_t rs,
		input mipsPkg::regAddr_t rt);
		return {mipsPkg::rType, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic mipsPkg::word_t encodeI(input mipsPkg::opcode_t op,
		input mipsPkg::regAddr_t rt, input mipsPkg::regAddr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// beq r0, r0, -1 spins on itself
	function automatic mipsPkg::word_t haltInstr();
		return encodeI(mipsPkg::beq, 5'd0, 5'd0, 16'hffff);
	endfunction

	// every immediate is sign extended by the core, andi too
	function automatic mipsPkg::word_t signExtend(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic mipsPkg::word_t lessThan(input mipsPkg::word_t a, input mipsPkg::word_t b);
		return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	endfunction

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic checkValue(input string testName, input string what,
		input mipsPkg::word_t expected, input mipsPkg::word_t actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("Mismatch in %s, %s: expected %h, actual %h",
				testName, what, expected, actual);
			testErrors++;
		end
	endtask

	// reset, then write the whole store, the tail as no-ops
	task automatic loadProgram();
		@(negedge clk);
		reset = 1'b1;
		run = 1'b0;
		repeat (resetCycles) @(negedge clk);
		// core stays paused while the store is written
		reset = 1'b0;
		for (int i = 0; i < imemWords; i++)
		begin
			imemWe = 1'b1;
			imemAddr = addrBits'(i);
			imemData = (i < code.size()) ? code[i] : 32'd0;
			@(negedge clk);
		end
		imemWe = 1'b0;
		run = 1'b1;
	endtask

	// halt is last, it is in memory once pc wraps from halt+12 back to halt
	task automatic waitForHalt(input string testName, input int budget);
		mipsPkg::word_t haltAddr;
		mipsPkg::word_t prevPc;
		logic done;
		int cycles;
		haltAddr = 32'(code.size() - 1) << 2;
		prevPc = pc;
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < budget)
		begin
			@(negedge clk);
			cycles++;
			if (prevPc == haltAddr + 32'd12 && pc == haltAddr)
				done = 1'b1;
			prevPc = pc;
		end
		if (!done)
		begin
			$display("%s: program did not reach its halt within %0d cycles", testName, budget);
			testErrors++;
		end
		repeat (drainCycles) @(negedge clk);
		run = 1'b0;
	endtask

	task automatic readReg(input mipsPkg::regAddr_t r, output mipsPkg::word_t v);
		@(negedge clk);
		dbgAddr = r;
		#1;
		v = dbgData;
	endtask

	task automatic checkReg(input string testName, input mipsPkg::regAddr_t r,
		input mipsPkg::word_t expected);
		mipsPkg::word_t v;
		readReg(r, v);
		checkValue(testName, $sformatf("r%0d", r), expected, v);
	endtask

	task automatic finishTest(input string testName);
		$display("%s: %s, %0d errors", testName, (testErrors == 0) ? "ok" : "failed", testErrors);
		errorCount += testErrors;
		testErrors = 0;
		testCount++;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic testArith();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immC;
		mipsPkg::word_t a;
		mipsPkg::word_t b;
		immA = 16'($urandom);
		immB = 16'($urandom);
		immC = 16'($urandom);
		a = signExtend(immA);
		b = signExtend(immB);
		// three no-ops so every operand comes from the register file
		// r0 write is dropped and the next add must not see it forwarded
		code = {encodeI(mipsPkg::addi, 5'd1, 5'd0, immA),
			encodeI(mipsPkg::addi, 5'd2, 5'd0, immB), 32'd0, 32'd0, 32'd0,
			encodeI(mipsPkg::andi, 5'd3, 5'd1, immC),
			encodeR(mipsPkg::functAdd, 5'd4, 5'd1, 5'd2),
			encodeR(mipsPkg::functSub, 5'd5, 5'd1, 5'd2),
			encodeR(mipsPkg::functAnd, 5'd6, 5'd1, 5'd2),
			encodeR(mipsPkg::functOr, 5'd7, 5'd1, 5'd2),
			encodeR(mipsPkg::functSlt, 5'd8, 5'd1, 5'd2),
			encodeR(mipsPkg::functSlt, 5'd9, 5'd2, 5'd1),
			encodeI(mipsPkg::addi, 5'd0, 5'd1, immC),
			encodeR(mipsPkg::functAdd, 5'd10, 5'd0, 5'd2), haltInstr()};
		loadProgram();
		waitForHalt("arith", arithBudget);
		checkReg("arith", 5'd1, a);
		checkReg("arith", 5'd2, b);
		checkReg("arith", 5'd3, a & signExtend(immC));
		checkReg("arith", 5'd4, a + b);
		checkReg("arith", 5'd5, a - b);
		checkReg("arith", 5'd6, a & b);
		checkReg("arith", 5'd7, a | b);
		checkReg("arith", 5'd8, lessThan(a, b));
		checkReg("arith", 5'd9, lessThan(b, a));
		checkReg("arith", 5'd0, 32'd0);
		checkReg("arith", 5'd10, b);
		finishTest("arith");
	endtask

	task automatic testForwarding();
		logic [15:0] immD;
		logic [15:0] immE;
		mipsPkg::word_t r [10];
		immD = 16'($urandom);
		immE = 16'($urandom);
		r[1] = signExtend(immD);
		r[2] = r[1] + signExtend(immE);
		r[3] = r[2] + r[1];
		r[4] = r[3] - r[2];
		r[5] = r[4] | r[3];
		r[6] = lessThan(r[5], r[4]);
		// both stages hold r7, the younger value wins
		r[7] = (32'd3 + 32'd5) * 2;
		r[8] = r[7] & r[5];
		code = {encodeI(mipsPkg::addi, 5'd1, 5'd0, immD),
			encodeI(mipsPkg::addi, 5'd2, 5'd1, immE),
			encodeR(mipsPkg::functAdd, 5'd3, 5'd2, 5'd1),
			encodeR(mipsPkg::functSub, 5'd4, 5'd3, 5'd2),
			encodeR(mipsPkg::functOr, 5'd5, 5'd4, 5'd3),
			encodeR(mipsPkg::functSlt, 5'd6, 5'd5, 5'd4),
			encodeI(mipsPkg::addi, 5'd7, 5'd0, 16'd3),
			encodeI(mipsPkg::addi, 5'd7, 5'd7, 16'd5),
			encodeR(mipsPkg::functAdd, 5'd7, 5'd7, 5'd7),
			encodeR(mipsPkg::functAnd, 5'd8, 5'd7, 5'd5), haltInstr()};
		loadProgram();
		waitForHalt("forwarding", fwdBudget);
		for (int i = 1; i <= 8; i++)
			checkReg("forwarding", 5'(i), r[i]);
		finishTest("forwarding");
	endtask

	task automatic testMemory();
		mipsPkg::word_t v1;
		mipsPkg::word_t v2;
		v1 = 32'h0000_1234;
		v2 = 32'hffff_fff9;
		// base in r9, every load used by the next instruction
		code = {encodeI(mipsPkg::addi, 5'd1, 5'd0, 16'h1234),
			encodeI(mipsPkg::addi, 5'd2, 5'd0, 16'hfff9),
			encodeI(mipsPkg::addi, 5'd9, 5'd0, 16'd16),
			encodeI(mipsPkg::sw, 5'd1, 5'd9, 16'd0),
			encodeI(mipsPkg::sw, 5'd2, 5'd9, 16'd4),
			encodeI(mipsPkg::lw, 5'd3, 5'd9, 16'd0),
			encodeR(mipsPkg::functAdd, 5'd4, 5'd3, 5'd3),
			encodeI(mipsPkg::lw, 5'd5, 5'd9, 16'd4),
			encodeR(mipsPkg::functAdd, 5'd6, 5'd5, 5'd4),
			encodeI(mipsPkg::sw, 5'd6, 5'd9, 16'd8),
			encodeI(mipsPkg::lw, 5'd7, 5'd9, 16'd8),
			encodeR(mipsPkg::functSub, 5'd8, 5'd7, 5'd3), haltInstr()};
		loadProgram();
		waitForHalt("memory", memBudget);
		checkReg("memory", 5'd3, v1);
		checkReg("memory", 5'd4, v1 + v1);
		checkReg("memory", 5'd5, v2);
		checkReg("memory", 5'd6, v2 + v1 + v1);
		checkReg("memory", 5'd7, v2 + v1 + v1);
		checkReg("memory", 5'd8, v2 + v1);
		finishTest("memory");
	endtask

	task automatic testBranch();
		// taken beq at 3 lands on 7, untaken beq at 8 falls through
		code = {encodeI(mipsPkg::addi, 5'd1, 5'd0, 16'd5),
			encodeI(mipsPkg::addi, 5'd2, 5'd0, 16'd5),
			encodeI(mipsPkg::addi, 5'd3, 5'd0, 16'd9),
			encodeI(mipsPkg::beq, 5'd2, 5'd1, 16'd3),
			encodeI(mipsPkg::addi, 5'd4, 5'd0, 16'd1),
			encodeI(mipsPkg::addi, 5'd5, 5'd0, 16'd2),
			encodeI(mipsPkg::addi, 5'd6, 5'd0, 16'd3),
			encodeI(mipsPkg::addi, 5'd7, 5'd0, 16'd4),
			encodeI(mipsPkg::beq, 5'd3, 5'd1, 16'd2),
			encodeI(mipsPkg::addi, 5'd8, 5'd0, 16'd6),
			encodeI(mipsPkg::addi, 5'd9, 5'd0, 16'd7), haltInstr()};
		loadProgram();
		waitForHalt("branch", branchBudget);
		checkReg("branch", 5'd4, 32'd0);
		checkReg("branch", 5'd5, 32'd0);
		checkReg("branch", 5'd6, 32'd0);
		checkReg("branch", 5'd7, 32'd4);
		checkReg("branch", 5'd8, 32'd6);
		checkReg("branch", 5'd9, 32'd7);
		finishTest("branch");
	endtask

	task automatic testPause();
		mipsPkg::word_t heldPc;
		mipsPkg::word_t heldR2;
		mipsPkg::word_t v;
		// countdown loop, r2 gains 3 per pass
		code = {encodeI(mipsPkg::addi, 5'd1, 5'd0, 16'd10),
			encodeI(mipsPkg::addi, 5'd2, 5'd0, 16'd0),
			encodeI(mipsPkg::addi, 5'd2, 5'd2, 16'd3),
			encodeI(mipsPkg::addi, 5'd1, 5'd1, 16'hffff),
			encodeI(mipsPkg::beq, 5'd0, 5'd1, 16'd1),
			encodeI(mipsPkg::beq, 5'd0, 5'd0, 16'hfffc),
			encodeR(mipsPkg::functAdd, 5'd3, 5'd2, 5'd1), haltInstr()};
		loadProgram();
		repeat (25) @(negedge clk);
		run = 1'b0;
		heldPc = pc;
		readReg(5'd2, heldR2);
		repeat (6)
		begin
			readReg(5'd2, v);
			checkValue("pause", "r2 while paused", heldR2, v);
			checkValue("pause", "pc while paused", heldPc, pc);
		end
		@(negedge clk);
		run = 1'b1;
		waitForHalt("pause", pauseBudget);
		checkReg("pause", 5'd1, 32'd0);
		checkReg("pause", 5'd2, 32'd30);
		checkReg("pause", 5'd3, 32'd30);
		finishTest("pause");
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		void'($urandom(32'he662_0f7e));
		reset = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		dbgAddr = '0;
		testArith();
		testForwarding();
		testMemory();
		testBranch();
		testPause();
		errorCount += UUT.props.failures;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			testCount, checkCount, errorCount, UUT.props.failures);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// hang guard
	initial
	begin
		#(watchdogTime);
		$display("watchdog expired after %0d time units, a test is stuck", watchdogTime);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/mipsPipeline_properties.sv
`default_nettype none

module mipsPipeline_properties (
	input logic                clk,
	input logic                reset,
	input logic                run,
	input logic                stall,
	input logic                branchTaken,
	input logic                regWriteEn,
	input logic                memWriteEn,
	input mipsPkg::word_t      pc,
	input logic [63:0]         ifIdBits,
	input mipsPkg::stageCtrl_t idExCtrl,
	input mipsPkg::memCtrl_t   exMemMem,
	input mipsPkg::wbCtrl_t    exMemWb,
	input mipsPkg::regAddr_t   dbgAddr,
	input mipsPkg::word_t      dbgData
);

	// failed assertions so far, read by the testbench summary
	int failures = 0;

	//////////////////////////////
	// held core writes nothing
	//////////////////////////////

	noWriteWhileHeld: assert property (@(posedge clk)
		(reset || !run) |-> !(regWriteEn || memWriteEn))
	else
	begin
		failures++;
		$error("register or data memory write while in reset or paused");
	end

	// load-use hold, a taken branch still redirects
	stallHoldsPc: assert property (@(posedge clk) disable iff (reset)
		(run && stall && !branchTaken) |=> (pc == $past(pc)))
	else
	begin
		failures++;
		$error("pc moved during a load-use stall");
	end

	//////////////////////////////
	// branch flush
	//////////////////////////////

	// IF/ID, ID/EX and EX/MEM all come out empty
	flushClearsYounger: assert property (@(posedge clk) disable iff (reset)
		(run && branchTaken) |=> (ifIdBits == '0) && (idExCtrl == '0)
			&& (exMemMem == '0) && (exMemWb == '0))
	else
	begin
		failures++;
		$error("taken branch left a younger stage with live control");
	end

	// r0 is hard wired
	zeroRegIsZero: assert property (@(posedge clk) disable iff (reset)
		(dbgAddr == '0) |-> (dbgData == '0))
	else
	begin
		failures++;
		$error("register zero read back nonzero");
	end

endmodule

bind mipsPipeline mipsPipeline_properties props (
	.clk(clk), .reset(reset), .run(run), .stall(stall), .branchTaken(branchTaken),
	.regWriteEn(regFile.writeEn), .memWriteEn(dmem.memWrite),
	.pc(pc), .ifIdBits(ifId), .idExCtrl(idExCtrl), .exMemMem(exMemMem),
	.exMemWb(exMemWb), .dbgAddr(dbgAddr), .dbgData(dbgData)
);

`default_nettype wire

// File: rtl/mipsPipeline.sv
`default_nettype none

module mipsPipeline #(
	parameter int imemWords = 64,
	parameter int dmemWords = 64
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         run,
	input  logic                         imemWe,
	input  logic [$clog2(imemWords)-1:0] imemAddr,
	input  mipsPkg::word_t               imemData,
	input  mipsPkg::regAddr_t            dbgAddr,
	output mipsPkg::word_t               dbgData,
	output mipsPkg::word_t               pc
);

	//////////////////////////////
	// pipeline register payloads
	//////////////////////////////

	typedef struct packed {
		mipsPkg::word_t instr;
		mipsPkg::word_t pcPlus4;
	} ifId_t;

	typedef struct packed {
		mipsPkg::word_t    rsData;
		mipsPkg::word_t    rtData;
		mipsPkg::word_t    imm;
		mipsPkg::word_t    pcPlus4;
		mipsPkg::regAddr_t rs;
		mipsPkg::regAddr_t rt;
		mipsPkg::regAddr_t rd;
	} idEx_t;

	typedef struct packed {
		mipsPkg::word_t    aluResult;
		mipsPkg::word_t    storeData;
		mipsPkg::word_t    branchTarget;
		logic              zero;
		mipsPkg::regAddr_t destReg;
	} exMem_t;

	typedef struct packed {
		mipsPkg::word_t    aluResult;
		mipsPkg::word_t    readData;
		mipsPkg::regAddr_t destReg;
	} memWb_t;

	// stage registers, control kept apart from payload
	ifId_t ifId;
	mipsPkg::stageCtrl_t idExCtrl;
	idEx_t idEx;
	mipsPkg::memCtrl_t exMemMem;
	mipsPkg::wbCtrl_t exMemWb;
	exMem_t exMem;
	mipsPkg::wbCtrl_t memWbWb;
	memWb_t memWb;

	// fetch and decode
	mipsPkg::word_t pcPlus4;
	mipsPkg::word_t fetchedInstr;
	mipsPkg::stageCtrl_t decodeCtrl;
	mipsPkg::word_t rsData;
	mipsPkg::word_t rtData;
	mipsPkg::word_t decodeImm;

	// hazard and execute
	mipsPkg::fwdSel_t forwardA;
	mipsPkg::fwdSel_t forwardB;
	logic stall;
	mipsPkg::word_t exAluResult;
	mipsPkg::word_t exStoreData;
	mipsPkg::word_t exBranchTarget;
	logic exZero;
	mipsPkg::regAddr_t exDestReg;

	// memory and writeback
	mipsPkg::word_t memReadData;
	mipsPkg::word_t wbResult;
	logic branchTaken;

	//////////////////////////////
	// fetch
	//////////////////////////////

	assign pcPlus4 = pc + mipsPkg::pcStep;
	// resolved in memory, flush outranks the load-use hold
	assign branchTaken = exMemMem.branch && exMem.zero;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pc <= '0;
		else if (run)
		begin
			if (branchTaken)
				pc <= exMem.branchTarget;
			else if (!stall)
				pc <= pcPlus4;
		end
	end

	instrMemory #(.imemWords(imemWords)) imem (
		.clk(clk), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.pc(pc), .instr(fetchedInstr)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ifId <= '0;
		else if (run)
		begin
			// all-zero word is a no-op
			if (branchTaken)
				ifId <= '0;
			else if (!stall)
				ifId <= '{instr: fetchedInstr, pcPlus4: pcPlus4};
		end
	end

	//////////////////////////////
	// decode
	//////////////////////////////

	controlDecoder decoder (.instr(ifId.instr), .ctrl(decodeCtrl));

	// register writes freeze with the rest of the core
	registerFile regFile (
		.clk(clk), .reset(reset), .writeEn(memWbWb.regWrite && run),
		.rsAddr(ifId.instr[25:21]), .rtAddr(ifId.instr[20:16]),
		.writeAddr(memWb.destReg), .dbgAddr(dbgAddr), .writeData(wbResult),
		.rsData(rsData), .rtData(rtData), .dbgData(dbgData)
	);

	assign decodeImm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

	hazardUnit hazards (
		.ifIdRs(ifId.instr[25:21]), .ifIdRt(ifId.instr[20:16]),
		.idExRs(idEx.rs), .idExRt(idEx.rt), .exMemRd(exMem.destReg),
		.memWbRd(memWb.destReg), .idExMemRead(idExCtrl.mem.memRead),
		.exMemRegWrite(exMemWb.regWrite), .memWbRegWrite(memWbWb.regWrite),
		.forwardA(forwardA), .forwardB(forwardB), .stall(stall)
	);

	// bubble on stall or flush
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			idExCtrl <= '0;
		else if (run)
			idExCtrl <= (branchTaken || stall) ? '0 : decodeCtrl;
	end

	always_ff @(posedge clk)
	begin
		if (run)
			idEx <= '{rsData: rsData, rtData: rtData, imm: decodeImm,
				pcPlus4: ifId.pcPlus4, rs: ifId.instr[25:21],
				rt: ifId.instr[20:16], rd: ifId.instr[15:11]};
	end

	//////////////////////////////
	// execute
	//////////////////////////////

	executeStage execute (
		.ctrl(idExCtrl.ex), .forwardA(forwardA), .forwardB(forwardB),
		.rsData(idEx.rsData), .rtData(idEx.rtData), .imm(idEx.imm),
		.pcPlus4(idEx.pcPlus4), .memResult(exMem.aluResult), .wbResult(wbResult),
		.rt(idEx.rt), .rd(idEx.rd), .aluResult(exAluResult),
		.storeData(exStoreData), .branchTarget(exBranchTarget),
		.zero(exZero), .destReg(exDestReg)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			exMemMem <= '0;
			exMemWb <= '0;
		end
		else if (run)
		begin
			exMemMem <= branchTaken ? '0 : idExCtrl.mem;
			exMemWb <= branchTaken ? '0 : idExCtrl.wb;
		end
	end

	always_ff @(posedge clk)
	begin
		if (run)
			exMem <= '{aluResult: exAluResult, storeData: exStoreData,
				branchTarget: exBranchTarget, zero: exZero, destReg: exDestReg};
	end

	//////////////////////////////
	// memory and writeback
	//////////////////////////////

	dataMemory #(.dmemWords(dmemWords)) dmem (
		.clk(clk), .reset(reset), .memWrite(exMemMem.memWrite && run),
		.addr(exMem.aluResult), .writeData(exMem.storeData), .readData(memReadData)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			memWbWb <= '0;
		else if (run)
			memWbWb <= exMemWb;
	end

	always_ff @(posedge clk)
	begin
		if (run)
			memWb <= '{aluResult: exMem.aluResult, readData: memReadData,
				destReg: exMem.destReg};
	end

	// load data or alu result back to the register file
	assign wbResult = memWbWb.memToReg ? memWb.readData : memWb.aluResult;

endmodule

`default_nettype wire

// File: rtl/dataMemory.sv
`default_nettype none

module dataMemory #(
	parameter int dmemWords = 64
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           memWrite,
	input  mipsPkg::word_t addr,
	input  mipsPkg::word_t writeData,
	output mipsPkg::word_t readData
);

	localparam int addrBits = $clog2(dmemWords);

	mipsPkg::word_t mem [dmemWords];
	// byte address to word index
	mipsPkg::word_t wordIndex;
	logic inRange;

	assign wordIndex = addr >> 2;
	assign inRange = wordIndex < dmemWords;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < dmemWords; i++)
				mem[i] <= '0;
		end
		// stores outside the array are dropped
		else if (memWrite && inRange)
			mem[wordIndex[addrBits-1:0]] <= writeData;
	end

	assign readData = inRange ? mem[wordIndex[addrBits-1:0]] : '0;

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
`default_nettype none

module executeStage (
	input  mipsPkg::exCtrl_t  ctrl,
	input  mipsPkg::fwdSel_t  forwardA,
	input  mipsPkg::fwdSel_t  forwardB,
	input  mipsPkg::word_t    rsData,
	input  mipsPkg::word_t    rtData,
	input  mipsPkg::word_t    imm,
	input  mipsPkg::word_t    pcPlus4,
	input  mipsPkg::word_t    memResult,
	input  mipsPkg::word_t    wbResult,
	input  mipsPkg::regAddr_t rt,
	input  mipsPkg::regAddr_t rd,
	output mipsPkg::word_t    aluResult,
	output mipsPkg::word_t    storeData,
	output mipsPkg::word_t    branchTarget,
	output logic              zero,
	output mipsPkg::regAddr_t destReg
);

	// operand a after forwarding
	mipsPkg::word_t opA;
	// operand b before and after the immediate select
	mipsPkg::word_t fwdB;
	mipsPkg::word_t opB;

	//////////////////////////////
	// operand select
	//////////////////////////////

	function automatic mipsPkg::word_t selectOperand(
		input mipsPkg::fwdSel_t sel,
		input mipsPkg::word_t regValue
	);
		case (sel)
			mipsPkg::fromMemory:    return memResult;
			mipsPkg::fromWriteback: return wbResult;
			default:                return regValue;
		endcase
	endfunction

	assign opA = selectOperand(forwardA, rsData);
	assign fwdB = selectOperand(forwardB, rtData);
	assign opB = ctrl.aluSrc ? imm : fwdB;

	// sw stores the forwarded rt, not the immediate
	assign storeData = fwdB;

	//////////////////////////////
	// alu
	//////////////////////////////

	always_comb
	begin
		case (ctrl.aluOp)
			mipsPkg::aluAnd:  aluResult = opA & opB;
			mipsPkg::aluOr:   aluResult = opA | opB;
			mipsPkg::aluAdd:  aluResult = opA + opB;
			mipsPkg::aluSub:  aluResult = opA - opB;
			// two's complement compare
			mipsPkg::aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
			mipsPkg::aluPass: aluResult = opB;
			default:          aluResult = '0;
		endcase
	end

	// equality flag for beq
	assign zero = (ctrl.aluOp == mipsPkg::aluSub) && (opA == opB);

	// word offset to byte offset
	assign branchTarget = pcPlus4 + (imm << 2);

	// rd for r-type, rt for i-type
	assign destReg = ctrl.regDst ? rd : rt;

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`default_nettype none

module hazardUnit (
	input  mipsPkg::regAddr_t ifIdRs,
	input  mipsPkg::regAddr_t ifIdRt,
	input  mipsPkg::regAddr_t idExRs,
	input  mipsPkg::regAddr_t idExRt,
	input  mipsPkg::regAddr_t exMemRd,
	input  mipsPkg::regAddr_t memWbRd,
	input  logic              idExMemRead,
	input  logic              exMemRegWrite,
	input  logic              memWbRegWrite,
	output mipsPkg::fwdSel_t  forwardA,
	output mipsPkg::fwdSel_t  forwardB,
	output logic              stall
);

	// source for one execute operand, memory stage is younger so it wins
	function automatic mipsPkg::fwdSel_t pickSource(input mipsPkg::regAddr_t src);
		if (exMemRegWrite && (exMemRd != '0) && (exMemRd == src))
			return mipsPkg::fromMemory;
		else if (memWbRegWrite && (memWbRd != '0) && (memWbRd == src))
			return mipsPkg::fromWriteback;
		else
			return mipsPkg::fromRegs;
	endfunction

	assign forwardA = pickSource(idExRs);
	assign forwardB = pickSource(idExRt);

	// load in execute whose target is read in decode
	// data exists only after memory, so hold one cycle
	assign stall = idExMemRead && (idExRt != '0)
		&& ((idExRt == ifIdRs) || (idExRt == ifIdRt));

endmodule

`default_nettype wire

// File: rtl/controlDecoder.sv
`default_nettype none

module controlDecoder (
	input  mipsPkg::word_t     instr,
	output mipsPkg::stageCtrl_t ctrl
);

	//////////////////////////////
	// opcode and funct decode
	//////////////////////////////

	// one flat decode, no separate alu control step
	always_comb
	begin
		ctrl = '0;
		case (mipsPkg::opcode_t'(instr[31:26]))
			mipsPkg::rType:
			begin
				// funct picks the op, anything unknown stays a no-op
				ctrl.ex.regDst = 1'b1;
				ctrl.wb.regWrite = 1'b1;
				case (mipsPkg::funct_t'(instr[5:0]))
					mipsPkg::functAdd: ctrl.ex.aluOp = mipsPkg::aluAdd;
					mipsPkg::functSub: ctrl.ex.aluOp = mipsPkg::aluSub;
					mipsPkg::functAnd: ctrl.ex.aluOp = mipsPkg::aluAnd;
					mipsPkg::functOr:  ctrl.ex.aluOp = mipsPkg::aluOr;
					mipsPkg::functSlt: ctrl.ex.aluOp = mipsPkg::aluSlt;
					default:           ctrl = '0;
				endcase
			end
			mipsPkg::addi:
			begin
				ctrl.ex.aluSrc = 1'b1;
				ctrl.ex.aluOp = mipsPkg::aluAdd;
				ctrl.wb.regWrite = 1'b1;
			end
			mipsPkg::andi:
			begin
				// immediate arrives sign extended from decode
				ctrl.ex.aluSrc = 1'b1;
				ctrl.ex.aluOp = mipsPkg::aluAnd;
				ctrl.wb.regWrite = 1'b1;
			end
			mipsPkg::lw:
			begin
				ctrl.ex.aluSrc = 1'b1;
				ctrl.ex.aluOp = mipsPkg::aluAdd;
				ctrl.mem.memRead = 1'b1;
				ctrl.wb.regWrite = 1'b1;
				ctrl.wb.memToReg = 1'b1;
			end
			mipsPkg::sw:
			begin
				ctrl.ex.aluSrc = 1'b1;
				ctrl.ex.aluOp = mipsPkg::aluAdd;
				ctrl.mem.memWrite = 1'b1;
			end
			mipsPkg::beq:
			begin
				// subtract only to raise zero
				ctrl.ex.aluOp = mipsPkg::aluSub;
				ctrl.mem.branch = 1'b1;
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`default_nettype none

module registerFile (
	input  logic              clk,
	input  logic              reset,
	input  logic              writeEn,
	input  mipsPkg::regAddr_t rsAddr,
	input  mipsPkg::regAddr_t rtAddr,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::regAddr_t dbgAddr,
	input  mipsPkg::word_t    writeData,
	output mipsPkg::word_t    rsData,
	output mipsPkg::word_t    rtData,
	output mipsPkg::word_t    dbgData
);

	mipsPkg::word_t regs [32];
	// real write, register zero never takes one
	logic doWrite;

	assign doWrite = writeEn && (writeAddr != '0);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (doWrite)
			regs[writeAddr] <= writeData;
	end

	// bypass the writeback value so decode sees it in the same cycle
	assign rsData = (doWrite && (writeAddr == rsAddr)) ? writeData : regs[rsAddr];
	assign rtData = (doWrite && (writeAddr == rtAddr)) ? writeData : regs[rtAddr];

	// inspect port, plain array read
	assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

// File: rtl/instrMemory.sv
`default_nettype none

module instrMemory #(
	parameter int imemWords = 64
) (
	input  logic                         clk,
	input  logic                         imemWe,
	input  logic [$clog2(imemWords)-1:0] imemAddr,
	input  mipsPkg::word_t               imemData,
	input  mipsPkg::word_t               pc,
	output mipsPkg::word_t               instr
);

	localparam int addrBits = $clog2(imemWords);

	mipsPkg::word_t mem [imemWords];
	// word index from byte address
	mipsPkg::word_t wordIndex;

	// load port, written from outside while the core is held
	always_ff @(posedge clk)
	begin
		if (imemWe)
			mem[imemAddr] <= imemData;
	end

	assign wordIndex = pc >> 2;
	// past the end reads as all zero, decodes to a no-op
	assign instr = (wordIndex < imemWords) ? mem[wordIndex[addrBits-1:0]] : '0;

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	//////////////////////////////
	// basic widths
	//////////////////////////////

	// data word, also used for byte addresses
	typedef logic [31:0] word_t;

	// register number, 0 to 31
	typedef logic [4:0] regAddr_t;

	// byte distance between two instructions
	localparam word_t pcStep = 32'd4;

	//////////////////////////////
	// instruction fields
	//////////////////////////////

	// opcode field, bits 31:26
	typedef enum logic [5:0] {
		rType = 6'b000000,
		beq   = 6'b000100,
		addi  = 6'b001000,
		andi  = 6'b001100,
		lw    = 6'b100011,
		sw    = 6'b101011
	} opcode_t;

	// function field of r-type, bits 5:0
	typedef enum logic [5:0] {
		functAdd = 6'b100000,
		functSub = 6'b100010,
		functAnd = 6'b100100,
		functOr  = 6'b100101,
		functSlt = 6'b101010
	} funct_t;

	// operations the execute stage ALU knows
	typedef enum logic [2:0] {
		aluAnd  = 3'd0,
		aluOr   = 3'd1,
		aluAdd  = 3'd2,
		aluSub  = 3'd3,
		aluSlt  = 3'd4,
		aluPass = 3'd5
	} aluOp_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fromRegs      = 2'b00,
		fromWriteback = 2'b01,
		fromMemory    = 2'b10
	} fwdSel_t;

	//////////////////////////////
	// stage control
	//////////////////////////////

	// consumed in execute
	typedef struct packed {
		logic   regDst;
		logic   aluSrc;
		aluOp_t aluOp;
	} exCtrl_t;

	// consumed in memory
	typedef struct packed {
		logic branch;
		logic memRead;
		logic memWrite;
	} memCtrl_t;

	// consumed in writeback
	typedef struct packed {
		logic regWrite;
		logic memToReg;
	} wbCtrl_t;

	// everything decode hands to the ID/EX register
	typedef struct packed {
		exCtrl_t  ex;
		memCtrl_t mem;
		wbCtrl_t  wb;
	} stageCtrl_t;

endpackage

`default_nettype wire
